/* verilog/mem_system_cfg.svh */
// Memory system configuration
// Address map, bus widths, L2 geometry and core count
`ifndef MEM_SYSTEM_CFG_SVH
`define MEM_SYSTEM_CFG_SVH

// Host port
`define MS_ADDR_WIDTH 32
`define MS_DATA_WIDTH 32

// L2 memory geometry, 4 KiB in total
`define MS_NUM_L2_BANKS  4
`define MS_L2_BANK_WORDS 256
`define MS_L2_BASE       32'h8000_0000

// Control register window
`define MS_CTRL_BASE         32'h4000_0000
`define MS_CTRL_SIZE         32'h0000_1000
`define MS_CTRL_OFFSET_WIDTH 12

// Cluster description reported through the control registers
`define MS_NUM_CORES 8
`define MS_TCDM_BASE 32'h0000_0000
`define MS_TCDM_SIZE 32'h0010_0000

`endif

/* verilog/mem_system_pkg.sv */
// Memory system types
// Widths of the host port, the target offsets and the decoded region
`include "mem_system_cfg.svh"

package mem_system_pkg;

  // Host request fields
  typedef logic [`MS_ADDR_WIDTH-1:0]   addr_t;
  typedef logic [`MS_DATA_WIDTH-1:0]   data_t;
  typedef logic [`MS_DATA_WIDTH/8-1:0] strb_t;

  // Word offset inside the L2 region
  typedef logic [$clog2(`MS_NUM_L2_BANKS * `MS_L2_BANK_WORDS)-1:0] l2_addr_t;

  // Byte offset inside the control window
  typedef logic [`MS_CTRL_OFFSET_WIDTH-1:0] ctrl_offset_t;

  typedef logic [`MS_NUM_CORES-1:0] core_mask_t;  // One bit per core

  // Target selected by the address decode
  typedef enum logic [1:0] {
    REGION_NONE = 2'd0,
    REGION_L2   = 2'd1,
    REGION_CTRL = 2'd2
  } region_e;

endpackage

/* verilog/l2_banked_mem.sv */
`timescale 1ns/1ps
`include "mem_system_cfg.svh"

// L2 memory made of word-interleaved banks
// Byte-strobe writes, reads answered one cycle after the request
module l2_banked_mem
  import mem_system_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     req_i,
  input  logic     we_i,
  input  l2_addr_t addr_i,
  input  data_t    wdata_i,
  input  strb_t    strb_i,
  output data_t    rdata_o
);

  localparam int unsigned NUM_BANKS  = `MS_NUM_L2_BANKS;
  localparam int unsigned BANK_WORDS = `MS_L2_BANK_WORDS;
  localparam int unsigned BANK_BITS  = $clog2(NUM_BANKS);
  localparam int unsigned WORD_BITS  = $clog2(BANK_WORDS);
  localparam int unsigned NUM_BYTES  = `MS_DATA_WIDTH / 8;

  logic [BANK_BITS-1:0] bank_sel;
  logic [WORD_BITS-1:0] word_sel;
  logic [BANK_BITS-1:0] bank_sel_q;
  data_t                bank_rdata [NUM_BANKS];

  assign bank_sel = addr_i[BANK_BITS-1:0];          // Interleave on the lowest word bits
  assign word_sel = addr_i[BANK_BITS +: WORD_BITS]; // Row inside the bank

  // Bank that owns the read data of the next cycle
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      bank_sel_q <= '0;
    end else if (req_i && !we_i) begin
      bank_sel_q <= bank_sel;
    end
  end

  for (genvar b = 0; b < NUM_BANKS; b++) begin : gen_banks
    data_t mem_q [BANK_WORDS];
    data_t rdata_q;
    logic  bank_req;

    assign bank_req = req_i && (bank_sel == BANK_BITS'(b));

    always_ff @(posedge clk_i) begin
      if (bank_req) begin
        if (we_i) begin
          // Only the enabled byte lanes change
          for (int i = 0; i < NUM_BYTES; i++) begin
            if (strb_i[i]) begin
              mem_q[word_sel][8*i +: 8] <= wdata_i[8*i +: 8];
            end
          end
        end else begin
          rdata_q <= mem_q[word_sel];
        end
      end
    end

    assign bank_rdata[b] = rdata_q;
  end

  assign rdata_o = bank_rdata[bank_sel_q];  // Output mux after the bank registers

  // Every request lands in an existing bank
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_i |-> (bank_sel < NUM_BANKS))
    else $error("L2 bank index out of range");

endmodule

/* verilog/ctrl_registers.sv */
`timescale 1ns/1ps
`include "mem_system_cfg.svh"

// Control and status registers
// End-of-computation flag, core wake-up pulse and memory description
module ctrl_registers
  import mem_system_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  logic         req_i,
  input  logic         we_i,
  input  ctrl_offset_t offset_i,
  input  data_t        wdata_i,
  output data_t        rdata_o,
  output logic         eoc_valid_o,
  output core_mask_t   wake_up_o
);

  // Register map
  localparam ctrl_offset_t OFF_EOC        = ctrl_offset_t'('h00);
  localparam ctrl_offset_t OFF_WAKE_UP    = ctrl_offset_t'('h04);
  localparam ctrl_offset_t OFF_TCDM_START = ctrl_offset_t'('h08);
  localparam ctrl_offset_t OFF_TCDM_END   = ctrl_offset_t'('h0C);
  localparam ctrl_offset_t OFF_NUM_CORES  = ctrl_offset_t'('h10);

  // Read-only values
  localparam data_t TCDM_START = `MS_TCDM_BASE;
  localparam data_t TCDM_END   = `MS_TCDM_BASE + `MS_TCDM_SIZE;
  localparam data_t CORE_COUNT = data_t'(`MS_NUM_CORES);

  data_t      eoc_q;
  core_mask_t wake_up_q;
  data_t      rdata_q;
  data_t      read_value;
  logic       wr_eoc;
  logic       wr_wake_up;

  assign wr_eoc     = req_i && we_i && (offset_i == OFF_EOC);
  assign wr_wake_up = req_i && we_i && (offset_i == OFF_WAKE_UP);

  // End of computation, bit 0 is the valid flag
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      eoc_q <= '0;
    end else if (wr_eoc) begin
      eoc_q <= wdata_i;
    end
  end

  // Wake-up lasts a single cycle after the write
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wake_up_q <= '0;
    end else if (wr_wake_up) begin
      wake_up_q <= (wdata_i == '1) ? '1 : core_mask_t'(wdata_i); // All ones wakes every core
    end else begin
      wake_up_q <= '0;
    end
  end

  always_comb begin
    case (offset_i)
      OFF_EOC:        read_value = eoc_q;
      OFF_TCDM_START: read_value = TCDM_START;
      OFF_TCDM_END:   read_value = TCDM_END;
      OFF_NUM_CORES:  read_value = CORE_COUNT;
      default:        read_value = '0;  // Wake-up and unmapped offsets
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      rdata_q <= read_value;
    end
  end

  assign rdata_o     = rdata_q;
  assign eoc_valid_o = eoc_q[0];
  assign wake_up_o   = wake_up_q;

  // No core is woken unless the wake-up register was written the cycle before
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (wake_up_o != '0) |-> $past(wr_wake_up))
    else $error("Wake-up pulse without a preceding write");

endmodule

/* verilog/mem_router.sv */
`timescale 1ns/1ps
`include "mem_system_cfg.svh"

// Request router of the memory system
// Decodes the host address, steers the strobe and merges the responses
module mem_router
  import mem_system_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_n_i,
  // Host request
  input  logic         req_i,
  input  logic         we_i,
  input  addr_t        addr_i,
  input  data_t        wdata_i,
  input  strb_t        strb_i,
  // L2 memory
  output logic         l2_req_o,
  output logic         l2_we_o,
  output l2_addr_t     l2_addr_o,
  output data_t        l2_wdata_o,
  output strb_t        l2_strb_o,
  input  data_t        l2_rdata_i,
  // Control registers
  output logic         ctrl_req_o,
  output logic         ctrl_we_o,
  output ctrl_offset_t ctrl_offset_o,
  output data_t        ctrl_wdata_o,
  input  data_t        ctrl_rdata_i,
  // Host response
  output logic         rvalid_o,
  output data_t        rdata_o,
  output logic         err_o
);

  localparam int unsigned BYTE_BITS = $clog2(`MS_DATA_WIDTH / 8);
  localparam int unsigned L2_BYTES  = `MS_NUM_L2_BANKS * `MS_L2_BANK_WORDS * (`MS_DATA_WIDTH / 8);

  localparam addr_t L2_BASE   = `MS_L2_BASE;
  localparam addr_t L2_END    = `MS_L2_BASE + L2_BYTES;
  localparam addr_t CTRL_BASE = `MS_CTRL_BASE;
  localparam addr_t CTRL_END  = `MS_CTRL_BASE + `MS_CTRL_SIZE;

  region_e region_d;
  region_e region_q;
  logic    valid_q;
  logic    write_q;

  // Each window holds its base but not base plus size
  always_comb begin
    region_d = REGION_NONE;
    if ((addr_i >= L2_BASE) && (addr_i < L2_END)) begin
      region_d = REGION_L2;
    end else if ((addr_i >= CTRL_BASE) && (addr_i < CTRL_END)) begin
      region_d = REGION_CTRL;
    end
  end

  // Strobe goes to one target at most, unmapped requests reach none
  assign l2_req_o      = req_i && (region_d == REGION_L2);
  assign l2_we_o       = we_i;
  assign l2_addr_o     = l2_addr_t'((addr_i - L2_BASE) >> BYTE_BITS);
  assign l2_wdata_o    = wdata_i;
  assign l2_strb_o     = strb_i;

  assign ctrl_req_o    = req_i && (region_d == REGION_CTRL);
  assign ctrl_we_o     = we_i;
  assign ctrl_offset_o = ctrl_offset_t'(addr_i - CTRL_BASE);
  assign ctrl_wdata_o  = wdata_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q  <= 1'b0;
      region_q <= REGION_NONE;
      write_q  <= 1'b0;
    end else begin
      valid_q <= req_i;  // Every request is answered
      if (req_i) begin
        region_q <= region_d;
        write_q  <= we_i;
      end
    end
  end

  // Response merge, writes and errors return zero data
  always_comb begin
    rdata_o = '0;
    if (valid_q && !write_q) begin
      case (region_q)
        REGION_L2:   rdata_o = l2_rdata_i;
        REGION_CTRL: rdata_o = ctrl_rdata_i;
        default:     rdata_o = '0;
      endcase
    end
  end

  assign rvalid_o = valid_q;
  assign err_o    = valid_q && (region_q == REGION_NONE);

  // An error answers a request of the previous cycle whose strobe reached no target
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    err_o |-> (rvalid_o && $past(req_i && !l2_req_o && !ctrl_req_o)))
    else $error("Error flag without an unrouted request before it");

endmodule

/* verilog/mem_system_top.sv */
`timescale 1ns/1ps

// Memory system top level
// Host request port routed to the L2 memory and the control registers
module mem_system_top
  import mem_system_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  // Host request
  input  logic       req_i,
  input  logic       we_i,
  input  addr_t      addr_i,
  input  data_t      wdata_i,
  input  strb_t      strb_i,
  // Host response
  output logic       rvalid_o,
  output data_t      rdata_o,
  output logic       err_o,
  // Cluster control
  output core_mask_t wake_up_o,
  output logic       eoc_valid_o
);

  // Router to L2 memory
  logic         l2_req;
  logic         l2_we;
  l2_addr_t     l2_addr;
  data_t        l2_wdata;
  strb_t        l2_strb;
  data_t        l2_rdata;

  // Router to control registers
  logic         ctrl_req;
  logic         ctrl_we;
  ctrl_offset_t ctrl_offset;
  data_t        ctrl_wdata;
  data_t        ctrl_rdata;

  mem_router u_mem_router (
    .clk_i        (clk_i      ),
    .rst_n_i      (rst_n_i    ),
    .req_i        (req_i      ),
    .we_i         (we_i       ),
    .addr_i       (addr_i     ),
    .wdata_i      (wdata_i    ),
    .strb_i       (strb_i     ),
    .l2_req_o     (l2_req     ),
    .l2_we_o      (l2_we      ),
    .l2_addr_o    (l2_addr    ),
    .l2_wdata_o   (l2_wdata   ),
    .l2_strb_o    (l2_strb    ),
    .l2_rdata_i   (l2_rdata   ),
    .ctrl_req_o   (ctrl_req   ),
    .ctrl_we_o    (ctrl_we    ),
    .ctrl_offset_o(ctrl_offset),
    .ctrl_wdata_o (ctrl_wdata ),
    .ctrl_rdata_i (ctrl_rdata ),
    .rvalid_o     (rvalid_o   ),
    .rdata_o      (rdata_o    ),
    .err_o        (err_o      )
  );

  l2_banked_mem u_l2_banked_mem (
    .clk_i  (clk_i   ),
    .rst_n_i(rst_n_i ),
    .req_i  (l2_req  ),
    .we_i   (l2_we   ),
    .addr_i (l2_addr ),
    .wdata_i(l2_wdata),
    .strb_i (l2_strb ),
    .rdata_o(l2_rdata)
  );

  ctrl_registers u_ctrl_registers (
    .clk_i      (clk_i      ),
    .rst_n_i    (rst_n_i    ),
    .req_i      (ctrl_req   ),
    .we_i       (ctrl_we    ),
    .offset_i   (ctrl_offset),
    .wdata_i    (ctrl_wdata ),
    .rdata_o    (ctrl_rdata ),
    .eoc_valid_o(eoc_valid_o),
    .wake_up_o  (wake_up_o  )
  );

endmodule

/* sim/tb_mem_system.sv */
`timescale 1ns/1ps

// Testbench for the memory system
// Replays request vectors from the test data file and checks each response
module tb_mem_system
  import mem_system_pkg::*;
();

  localparam int    MAX_VECTORS = 128;
  localparam string DATA_FILE   = "sim/mem_system_testdata.txt";

  logic       clk_i;
  logic       rst_n_i;
  logic       req_i;
  logic       we_i;
  addr_t      addr_i;
  data_t      wdata_i;
  strb_t      strb_i;
  logic       rvalid_o;
  data_t      rdata_o;
  logic       err_o;
  core_mask_t wake_up_o;
  logic       eoc_valid_o;

  // Vector table, one entry per request line of the data file
  logic [7:0] test_id   [MAX_VECTORS];
  logic       vec_we    [MAX_VECTORS];
  addr_t      vec_addr  [MAX_VECTORS];
  data_t      vec_wdata [MAX_VECTORS];
  strb_t      vec_strb  [MAX_VECTORS];
  data_t      exp_rdata [MAX_VECTORS];
  data_t      exp_mask  [MAX_VECTORS];  // Zero bits are not compared
  logic       exp_err   [MAX_VECTORS];
  logic       exp_eoc   [MAX_VECTORS];
  core_mask_t exp_wake  [MAX_VECTORS];

  int   num_vectors   = 0;
  int   errors        = 0;
  int   test_errors   = 0;
  int   test_requests = 0;
  int   test_count    = 0;
  logic eoc_expected  = 1'b0;  // Last eoc_valid_o value seen in a response

  mem_system_top u_dut (
    .clk_i      (clk_i      ),
    .rst_n_i    (rst_n_i    ),
    .req_i      (req_i      ),
    .we_i       (we_i       ),
    .addr_i     (addr_i     ),
    .wdata_i    (wdata_i    ),
    .strb_i     (strb_i     ),
    .rvalid_o   (rvalid_o   ),
    .rdata_o    (rdata_o    ),
    .err_o      (err_o      ),
    .wake_up_o  (wake_up_o  ),
    .eoc_valid_o(eoc_valid_o)
  );

  initial clk_i = 1'b0;
  always #4 clk_i = ~clk_i;  // 8 ns period

  task automatic load_vectors(output logic ok);
    int          fd;
    int          count;
    string       line;
    logic [31:0] col [10];
    count = 0;
    fd = $fopen(DATA_FILE, "r");
    ok = (fd != 0);
    if (ok) begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() < 2 || line.getc(0) == "#") continue;  // Comments and blank lines
        if (count < MAX_VECTORS && $sscanf(line, "%h %h %h %h %h %h %h %h %h %h",
            col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7], col[8],
            col[9]) == 10) begin
          test_id[count]   = col[0][7:0];
          vec_we[count]    = col[1][0];
          vec_addr[count]  = col[2];
          vec_wdata[count] = col[3];
          vec_strb[count]  = col[4][3:0];
          exp_rdata[count] = col[5];
          exp_mask[count]  = col[6];
          exp_err[count]   = col[7][0];
          exp_eoc[count]   = col[8][0];
          exp_wake[count]  = col[9][7:0];
          count++;
        end
      end
      $fclose(fd);
    end
    ok = ok && (count > 0);
    num_vectors = count;
  endtask

  task count_error();
    errors++;
    test_errors++;
  endtask

  task drive_request(input int idx);
    req_i   <= 1'b1;
    we_i    <= vec_we[idx];
    addr_i  <= vec_addr[idx];
    wdata_i <= vec_wdata[idx];
    strb_i  <= vec_strb[idx];
  endtask

  task drive_idle();
    req_i   <= 1'b0;
    we_i    <= 1'b0;
    addr_i  <= '0;
    wdata_i <= '0;
    strb_i  <= '0;
  endtask

  // Compares the outputs of one cycle, had_req tells whether a request was sampled before it
  task automatic check_cycle(input logic had_req, input int idx);
    logic       want_err;
    core_mask_t want_wake;
    want_err  = had_req ? exp_err[idx] : 1'b0;
    want_wake = had_req ? exp_wake[idx] : '0;
    if (had_req) begin
      eoc_expected = exp_eoc[idx];
      assert (rvalid_o === 1'b1) else begin
        $display("Request %0d to address %h got no rvalid_o in the next cycle", idx,
                 vec_addr[idx]);
        count_error();
      end
      assert (((rdata_o ^ exp_rdata[idx]) & exp_mask[idx]) === '0) else begin
        $display("CHECK FAILED rdata_o got %h expected %h mask %h (request %0d)",
                 rdata_o, exp_rdata[idx], exp_mask[idx], idx);
        count_error();
      end
    end else begin
      assert (rvalid_o === 1'b0) else begin
        $display("rvalid_o was raised in a cycle that follows no request");
        count_error();
      end
    end
    assert (err_o === want_err) else begin
      $display("CHECK FAILED err_o got %h expected %h", err_o, want_err);
      count_error();
    end
    assert (eoc_valid_o === eoc_expected) else begin
      $display("CHECK FAILED eoc_valid_o got %h expected %h", eoc_valid_o, eoc_expected);
      count_error();
    end
    assert (wake_up_o === want_wake) else begin
      $display("CHECK FAILED wake_up_o got %h expected %h", wake_up_o, want_wake);
      count_error();
    end
    if (had_req) begin
      test_requests++;
      if ((idx == num_vectors - 1) || (test_id[idx + 1] != test_id[idx])) begin
        $display("Test %0d finished: %0d requests, %0d errors", test_id[idx],
                 test_requests, test_errors);
        test_count++;
        test_requests = 0;
        test_errors   = 0;
      end
    end
  endtask

  task automatic run_vectors();
    int   gap;
    int   prev;
    logic pending;
    prev    = 0;
    pending = 1'b0;
    for (int i = 0; i < num_vectors; i++) begin
      gap = $urandom_range(2, 0);
      repeat (gap) begin
        @(posedge clk_i);
        drive_idle();
        @(negedge clk_i);
        check_cycle(pending, prev);
        pending = 1'b0;
      end
      @(posedge clk_i);
      drive_request(i);
      @(negedge clk_i);
      check_cycle(pending, prev);  // Response of the previous request
      pending = 1'b1;
      prev    = i;
    end
    @(posedge clk_i);
    drive_idle();
    @(negedge clk_i);
    check_cycle(pending, prev);
    @(negedge clk_i);
    check_cycle(1'b0, prev);  // Outputs settle back after the last response
  endtask

  initial begin
    logic loaded;
    rst_n_i = 1'b0;
    req_i   = 1'b0;
    we_i    = 1'b0;
    addr_i  = '0;
    wdata_i = '0;
    strb_i  = '0;
    void'($urandom(32'hd4ac_79cf));
    load_vectors(loaded);
    if (!loaded) begin
      $display("Test data file %s is missing or holds no vectors", DATA_FILE);
      $display("Done: errors found");
      $finish;
    end else begin
      repeat (2) @(posedge clk_i);
      rst_n_i <= 1'b1;
      @(negedge clk_i);
      check_cycle(1'b0, 0);
      $display("Reset check finished: %0d errors", test_errors);
      test_errors = 0;
      run_vectors();
      $display("Summary: %0d tests, %0d requests, %0d errors", test_count, num_vectors,
               errors);
      if (errors == 0) begin
        $display("Done: no errors");
      end else begin
        $display("Done: errors found");
      end
      $finish;
    end
  end

  // Watchdog, at most three cycles per vector plus reset and drain
  initial begin
    wait (num_vectors > 0);
    #(num_vectors * 24 + 200);
    $display("Timeout: the run did not finish within the expected time");
    $display("Done: errors found");
    $finish;
  end

endmodule

/* flist.f */
+incdir+verilog
verilog/mem_system_pkg.sv
verilog/l2_banked_mem.sv
verilog/ctrl_registers.sv
verilog/mem_router.sv
verilog/mem_system_top.sv
sim/tb_mem_system.sv

/* run_sim.sh */
#!/bin/sh
# Build the memory system testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_mem_system \
  -o tb_mem_system || { echo "Verilator build failed"; exit 1; }

sim_out=$(./obj_dir/tb_mem_system 2>&1)
echo "$sim_out"
echo "$sim_out" | grep -qx "Done: no errors" && echo "Simulation passed" ||
  { echo "Simulation failed"; exit 1; }

/* sim/mem_system_testdata.txt */
# Columns, hex: test we addr wdata strb | expected rdata rdata_mask err eoc_valid wake_up
# rdata_mask bits at zero are not compared, used for never-written L2 words
1 0 40000010 00000000 0 00000008 ffffffff 0 0 00
1 0 40000000 00000000 0 00000000 ffffffff 0 0 00
2 1 80000000 11111111 f 00000000 ffffffff 0 0 00
2 1 80000004 22222222 f 00000000 ffffffff 0 0 00
2 1 80000008 33333333 f 00000000 ffffffff 0 0 00
2 1 8000000c 44444444 f 00000000 ffffffff 0 0 00
2 1 80000ffc a5a5a5a5 f 00000000 ffffffff 0 0 00
2 0 80000000 00000000 0 11111111 ffffffff 0 0 00
2 0 80000004 00000000 0 22222222 ffffffff 0 0 00
2 0 80000008 00000000 0 33333333 ffffffff 0 0 00
2 0 8000000c 00000000 0 44444444 ffffffff 0 0 00
2 0 80000ffc 00000000 0 a5a5a5a5 ffffffff 0 0 00
2 1 80000004 deadbeef 3 00000000 ffffffff 0 0 00
2 1 80000008 cafef00d c 00000000 ffffffff 0 0 00
2 1 8000000c 000000ab 1 00000000 ffffffff 0 0 00
2 1 80000000 99000000 8 00000000 ffffffff 0 0 00
2 0 80000004 00000000 0 2222beef ffffffff 0 0 00
2 0 80000008 00000000 0 cafe3333 ffffffff 0 0 00
2 0 8000000c 00000000 0 444444ab ffffffff 0 0 00
2 0 80000000 00000000 0 99111111 ffffffff 0 0 00
2 0 80000010 00000000 0 00000000 00000000 0 0 00
3 0 40000008 00000000 0 00000000 ffffffff 0 0 00
3 0 4000000c 00000000 0 00100000 ffffffff 0 0 00
3 0 40000010 00000000 0 00000008 ffffffff 0 0 00
3 1 40000008 12345678 f 00000000 ffffffff 0 0 00
3 1 4000000c 12345678 f 00000000 ffffffff 0 0 00
3 1 40000010 12345678 f 00000000 ffffffff 0 0 00
3 0 40000008 00000000 0 00000000 ffffffff 0 0 00
3 0 4000000c 00000000 0 00100000 ffffffff 0 0 00
3 0 40000010 00000000 0 00000008 ffffffff 0 0 00
3 0 40000014 00000000 0 00000000 ffffffff 0 0 00
3 0 40000004 00000000 0 00000000 ffffffff 0 0 00
4 1 40000000 00000001 f 00000000 ffffffff 0 1 00
4 0 40000000 00000000 0 00000001 ffffffff 0 1 00
4 1 40000000 a5a5a5a4 f 00000000 ffffffff 0 0 00
4 0 40000000 00000000 0 a5a5a5a4 ffffffff 0 0 00
4 1 40000000 00000003 f 00000000 ffffffff 0 1 00
4 0 40000000 00000000 0 00000003 ffffffff 0 1 00
5 1 40000004 00000005 f 00000000 ffffffff 0 1 05
5 0 40000000 00000000 0 00000003 ffffffff 0 1 00
5 1 40000004 ffffffff f 00000000 ffffffff 0 1 ff
5 1 40000004 00000100 f 00000000 ffffffff 0 1 00
5 1 40000004 fffffffe f 00000000 ffffffff 0 1 fe
5 0 40000004 00000000 0 00000000 ffffffff 0 1 00
6 0 80001000 00000000 0 00000000 ffffffff 1 1 00
6 1 80001000 12345678 f 00000000 ffffffff 1 1 00
6 0 7ffffffc 00000000 0 00000000 ffffffff 1 1 00
6 1 40001000 00000000 f 00000000 ffffffff 1 1 00
6 1 00000000 ffffffff f 00000000 ffffffff 1 1 00
6 1 ffffffff ffffffff f 00000000 ffffffff 1 1 00
6 0 40000000 00000000 0 00000003 ffffffff 0 1 00
6 0 80000000 00000000 0 99111111 ffffffff 0 1 00
6 0 80000ffc 00000000 0 a5a5a5a5 ffffffff 0 1 00
